// File: build.f
hdl/cache_pkg.sv
hdl/array_access_if.sv
hdl/line_ram.sv
hdl/line_state.sv
hdl/dirty_scan.sv
hdl/wb_burst_writer.sv
hdl/clean_ctrl.sv
hdl/cache_tag_ram_top.sv
verification/wb_mem_model.sv
verification/tb_cache_tag_ram.sv

// File: verification/tb_cache_tag_ram.sv
/*
 * Cache tag RAM testbench
 * Table-driven writes and reads, clean write-back over Wishbone,
 * empty clean and invalidate
 */
module tb_cache_tag_ram
        import cache_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

localparam int CACHE_SIZE     = 512;
localparam int CACHE_LINE     = 16;
localparam int LINES          = CACHE_SIZE / CACHE_LINE;
localparam int WORDS          = CACHE_LINE / 4;
localparam int ENTRIES        = 6;
localparam int TIMEOUT_CYCLES = ENTRIES * (WORDS * 4 + 8) + 500;

typedef struct packed {
        logic [7:0]              idx;
        logic [VA_TAG_W-1:0]     va_tag;
        logic [WB_AW-1:0]        pa_base;
        logic [CACHE_LINE*8-1:0] line;
        logic                    dirty;
} entry_t;

logic                    clk = 1'b0;
logic                    rst;
logic [31:0]             address_nxt;
logic [31:0]             address;
logic                    tag_wr_en;
tag_t                    wr_tag;
logic                    tag_dirty;
logic [CACHE_LINE*8-1:0] wr_line;
logic                    clean_req;
logic                    inv_req;
logic [CACHE_LINE*8-1:0] rd_line;
tag_t                    rd_tag;
logic                    rd_valid;
logic                    rd_dirty;
logic                    clean_done;
logic                    inv_done;
logic                    wb_cyc;
logic                    wb_stb;
logic                    wb_we;
logic                    wb_ack;
logic [WB_AW-1:0]        wb_adr;
logic [WB_DW-1:0]        wb_dat;
logic [WB_SEL_W-1:0]     wb_sel;
logic [2:0]              wb_cti;

entry_t           rows [ENTRIES];
logic [WB_AW-1:0] exp_adr [64];
logic [WB_DW-1:0] exp_dat [64];
logic [2:0]       exp_cti [64];
int               exp_count;
int               errors = 0;
int               cycles = 0;
int               log_before;

always #4 clk = ~clk;

cache_tag_ram_top #(
        .CACHE_SIZE (CACHE_SIZE),
        .CACHE_LINE (CACHE_LINE)
) dut0 (
        .i_clk (clk), .i_reset (rst), .i_address_nxt (address_nxt),
        .i_address (address), .i_tag_wr_en (tag_wr_en), .i_tag (wr_tag),
        .i_tag_dirty (tag_dirty), .i_line (wr_line), .i_clean_req (clean_req),
        .i_inv_req (inv_req), .i_wb_ack (wb_ack), .o_line (rd_line),
        .o_tag (rd_tag), .o_tag_valid (rd_valid), .o_tag_dirty (rd_dirty),
        .o_clean_done (clean_done), .o_inv_done (inv_done), .o_wb_cyc (wb_cyc),
        .o_wb_stb (wb_stb), .o_wb_we (wb_we), .o_wb_adr (wb_adr),
        .o_wb_dat (wb_dat), .o_wb_sel (wb_sel), .o_wb_cti (wb_cti)
);

wb_mem_model mem0 (
        .i_clk (clk), .i_reset (rst), .i_cyc (wb_cyc), .i_stb (wb_stb),
        .i_we (wb_we), .i_adr (wb_adr), .i_dat (wb_dat), .i_sel (wb_sel),
        .i_cti (wb_cti), .o_ack (wb_ack)
);

// Watchdog sized from the table length
always @(posedge clk)
begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
                $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("RESULT: FAIL");
                $finish;
        end
end

task automatic expect_eq(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act)
        begin
                $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
                errors++;
        end
endtask

// Index, virtual tag, physical base, line words high to low, dirty
task automatic load_table();
        rows[0] = {8'd2, 16'h1a02, 32'h0008_0020,
                   128'ha203_0003_a202_0002_a201_0001_a200_0000, 1'b1};
        rows[1] = {8'd5, 16'h1a05, 32'h0010_0050,
                   128'hb503_0013_b502_0012_b501_0011_b500_0010, 1'b0};
        rows[2] = {8'd17, 16'h2b11, 32'h0020_1110,
                   128'hc113_0023_c112_0022_c111_0021_c110_0020, 1'b1};
        rows[3] = {8'd9, 16'h1a09, 32'h0008_0090,
                   128'hd903_0033_d902_0032_d901_0031_d900_0030, 1'b1};
        rows[4] = {8'd30, 16'h2b1e, 32'h0040_01e0,
                   128'he303_0043_e302_0042_e301_0041_e300_0040, 1'b1};
        rows[5] = {8'd20, 16'h2b14, 32'h0030_0140,
                   128'hf203_0053_f202_0052_f201_0051_f200_0050, 1'b0};
endtask

// Dirty lines go out by ascending index, low word first
task automatic build_expected();
        exp_count = 0;
        for (int i = 0; i < LINES; i++)
        begin
                for (int r = 0; r < ENTRIES; r++)
                begin
                        if (rows[r].idx == i && rows[r].dirty)
                        begin
                                for (int w = 0; w < WORDS; w++)
                                begin
                                        exp_adr[exp_count] = rows[r].pa_base + 32'(4 * w);
                                        exp_dat[exp_count] = rows[r].line[w * 32 +: 32];
                                        exp_cti[exp_count] = (w == WORDS - 1) ? CTI_EOB : CTI_BURST;
                                        exp_count++;
                                end
                        end
                end
        end
endtask

task automatic write_row(input entry_t row);
        address   = 32'(row.idx) << 4;
        wr_tag    = {row.va_tag, row.pa_base};
        wr_line   = row.line;
        tag_dirty = row.dirty;
        tag_wr_en = 1'b1;
        @(negedge clk);
        tag_wr_en = 1'b0;
endtask

// Full mode also checks dirty, tag and line
task automatic read_check(input int idx, input logic exp_valid, input logic exp_dirty,
                          input logic full, input entry_t row, input string phase);
        address_nxt = 32'(idx) << 4;
        @(negedge clk);
        expect_eq($sformatf("%s idx %0d valid", phase, idx), exp_valid, rd_valid);
        if (full)
        begin
                expect_eq($sformatf("%s idx %0d dirty", phase, idx), exp_dirty, rd_dirty);
                expect_eq($sformatf("%s idx %0d tag", phase, idx),
                          {row.va_tag, row.pa_base}, rd_tag);
                expect_eq($sformatf("%s idx %0d line", phase, idx), row.line, rd_line);
        end
endtask

task automatic run_clean();
        clean_req = 1'b1;
        @(negedge clk);
        while (!clean_done)
        begin
                @(negedge clk);
        end
        clean_req = 1'b0;
endtask

initial
begin
        rst         = 1'b1;
        address_nxt = '0;
        address     = '0;
        tag_wr_en   = 1'b0;
        wr_tag      = '0;
        tag_dirty   = 1'b0;
        wr_line     = '0;
        clean_req   = 1'b0;
        inv_req     = 1'b0;
        load_table();
        build_expected();
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // ------------------------------
        // Empty after reset
        // ------------------------------
        for (int i = 0; i < LINES; i++)
        begin
                read_check(i, 1'b0, 1'b0, 1'b0, '0, "reset");
                if (wb_cyc || wb_stb || clean_done || inv_done)
                begin
                        $display("ERROR: bus or done output active after reset, index %0d", i);
                        errors++;
                end
        end

        for (int r = 0; r < ENTRIES; r++)
        begin
                write_row(rows[r]);
        end
        for (int r = 0; r < ENTRIES; r++)
        begin
                read_check(rows[r].idx, 1'b1, rows[r].dirty, 1'b1, rows[r], "written");
        end

        // ------------------------------
        // Clean with dirty lines in both groups
        // ------------------------------
        run_clean();
        expect_eq("clean write count", exp_count, mem0.log_count);
        for (int i = 0; i < exp_count && i < mem0.log_count; i++)
        begin
                expect_eq($sformatf("clean word %0d adr", i), exp_adr[i], mem0.log_adr[i]);
                expect_eq($sformatf("clean word %0d dat", i), exp_dat[i], mem0.log_dat[i]);
                expect_eq($sformatf("clean word %0d cti", i), exp_cti[i], mem0.log_cti[i]);
                expect_eq($sformatf("clean word %0d sel", i), 4'b1111, mem0.log_sel[i]);
        end
        for (int r = 0; r < ENTRIES; r++)
        begin
                read_check(rows[r].idx, 1'b1, 1'b0, 1'b1, rows[r], "cleaned");
        end

        // Nothing dirty, so no bus traffic
        log_before = mem0.log_count;
        run_clean();
        expect_eq("second clean write count", log_before, mem0.log_count);

        // ------------------------------
        // Invalidate
        // ------------------------------
        inv_req = 1'b1;
        @(negedge clk);
        while (!inv_done)
        begin
                @(negedge clk);
        end
        inv_req = 1'b0;
        for (int i = 0; i < LINES; i++)
        begin
                read_check(i, 1'b0, 1'b0, 1'b0, '0, "invalidated");
        end

        $display("Errors: %0d check, %0d bus protocol", errors, mem0.proto_errors);
        if (errors == 0 && mem0.proto_errors == 0)
        begin
                $display("RESULT: PASS");
        end
        else
        begin
                $display("RESULT: FAIL");
        end
        $finish;
end

endmodule

// File: verification/wb_mem_model.sv
/*
 * Wishbone memory model
 * Write slave with random wait states that logs each accepted transfer
 * and flags requests that change before their ack
 */
module wb_mem_model
        import cache_pkg::*;
#(
        parameter int LOG_DEPTH = 64
) (
        input  logic                i_clk,
        input  logic                i_reset,
        input  logic                i_cyc,
        input  logic                i_stb,
        input  logic                i_we,
        input  logic [WB_AW-1:0]    i_adr,
        input  logic [WB_DW-1:0]    i_dat,
        input  logic [WB_SEL_W-1:0] i_sel,
        input  logic [2:0]          i_cti,
        output logic                o_ack
);

timeunit 1ns;
timeprecision 100ps;

logic [WB_AW-1:0]    log_adr [LOG_DEPTH];
logic [WB_DW-1:0]    log_dat [LOG_DEPTH];
logic [2:0]          log_cti [LOG_DEPTH];
logic [WB_SEL_W-1:0] log_sel [LOG_DEPTH];
int                  log_count;
int                  proto_errors;

logic [31:0]      rng;
logic [31:0]      next_rng;
logic [1:0]       wait_target;
logic [1:0]       waited;
logic             held;
logic [WB_AW-1:0] held_adr;
logic [WB_DW-1:0] held_dat;

function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
endfunction

assign next_rng = xorshift(rng);

initial
begin
        o_ack = 1'b0;
end

always @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_ack        <= 1'b0;
                rng          <= 32'd36;
                wait_target  <= '0;
                waited       <= '0;
                held         <= 1'b0;
                log_count    <= 0;
                proto_errors <= 0;
        end
        else
        begin
                // A request left waiting last cycle must still be there unchanged
                if (held && (!i_stb || i_adr != held_adr || i_dat != held_dat))
                begin
                        $display("ERROR: bus request changed before its ack at %0t", $time);
                        proto_errors <= proto_errors + 1;
                end
                held     <= i_cyc && i_stb && !o_ack;
                held_adr <= i_adr;
                held_dat <= i_dat;

                // ------------------------------
                // Ack after 0 to 3 wait states
                // ------------------------------
                o_ack <= 1'b0;
                if (i_cyc && i_stb && !o_ack)
                begin
                        if (waited == wait_target)
                        begin
                                o_ack       <= 1'b1;
                                waited      <= '0;
                                rng         <= next_rng;
                                wait_target <= next_rng[1:0];
                        end
                        else
                        begin
                                waited <= waited + 1'b1;
                        end
                end

                if (i_cyc && i_stb && o_ack)
                begin
                        if (!i_we)
                        begin
                                $display("ERROR: read cycle seen where only writes belong");
                                proto_errors <= proto_errors + 1;
                        end
                        if (log_count < LOG_DEPTH)
                        begin
                                log_adr[log_count] <= i_adr;
                                log_dat[log_count] <= i_dat;
                                log_cti[log_count] <= i_cti;
                                log_sel[log_count] <= i_sel;
                        end
                        log_count <= log_count + 1;
                end
        end
end

endmodule

// File: hdl/cache_tag_ram_top.sv
/*
 * Cache tag and data array
 * Tag, line and state storage with a self-contained clean and
 * invalidate engine writing back over its own Wishbone master
 */
module cache_tag_ram_top
        import cache_pkg::*;
#(
        parameter int CACHE_SIZE = 512,
        parameter int CACHE_LINE = 16
) (
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic [31:0]             i_address_nxt,
        input  logic [31:0]             i_address,
        input  logic                    i_tag_wr_en,
        input  tag_t                    i_tag,
        input  logic                    i_tag_dirty,
        input  logic [CACHE_LINE*8-1:0] i_line,
        input  logic                    i_clean_req,
        input  logic                    i_inv_req,
        input  logic                    i_wb_ack,
        output logic [CACHE_LINE*8-1:0] o_line,
        output tag_t                    o_tag,
        output logic                    o_tag_valid,
        output logic                    o_tag_dirty,
        output logic                    o_clean_done,
        output logic                    o_inv_done,
        output logic                    o_wb_cyc,
        output logic                    o_wb_stb,
        output logic                    o_wb_we,
        output logic [WB_AW-1:0]        o_wb_adr,
        output logic [WB_DW-1:0]        o_wb_dat,
        output logic [WB_SEL_W-1:0]     o_wb_sel,
        output logic [2:0]              o_wb_cti
);

localparam int LINES  = CACHE_SIZE / CACHE_LINE;
localparam int IDX_W  = $clog2(LINES);
localparam int GROUPS = LINES / GROUP_LINES;
localparam int GRP_W  = (GROUPS > 1) ? $clog2(GROUPS) : 1;

logic [LINES-1:0] dirty_vec;
logic [GRP_W-1:0] group;
logic             found;
logic [IDX_W-1:0] found_index;
logic             wb_start;
logic             wb_done;

array_access_if #(.IDX_W(IDX_W)) acc_if ();

clean_ctrl #(
        .CACHE_SIZE (CACHE_SIZE),
        .CACHE_LINE (CACHE_LINE),
        .GRP_W      (GRP_W)
) u_clean_ctrl (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_address_nxt (i_address_nxt),
        .i_address     (i_address),
        .i_tag_wr_en   (i_tag_wr_en),
        .i_clean_req   (i_clean_req),
        .i_inv_req     (i_inv_req),
        .i_found       (found),
        .i_index       (found_index),
        .i_wb_done     (wb_done),
        .acc           (acc_if.ctrl),
        .o_group       (group),
        .o_wb_start    (wb_start),
        .o_clean_done  (o_clean_done),
        .o_inv_done    (o_inv_done)
);

line_ram #(.payload_t(tag_t), .DEPTH(LINES)) u_tag_ram (
        .i_clk      (i_clk),
        .i_wr_en    (acc_if.wr_en),
        .i_wr_index (acc_if.wr_index),
        .i_wr_data  (i_tag),
        .i_rd_index (acc_if.rd_index),
        .o_rd_data  (o_tag)
);

line_ram #(.payload_t(logic [CACHE_LINE*8-1:0]), .DEPTH(LINES)) u_data_ram (
        .i_clk      (i_clk),
        .i_wr_en    (acc_if.wr_en),
        .i_wr_index (acc_if.wr_index),
        .i_wr_data  (i_line),
        .i_rd_index (acc_if.rd_index),
        .o_rd_data  (o_line)
);

line_state #(.LINES(LINES)) u_line_state (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_tag_dirty (i_tag_dirty),
        .acc         (acc_if.array),
        .o_valid     (o_tag_valid),
        .o_dirty     (o_tag_dirty),
        .o_dirty_vec (dirty_vec)
);

dirty_scan #(.LINES(LINES), .GRP_W(GRP_W)) u_dirty_scan (
        .i_dirty_vec (dirty_vec),
        .i_group     (group),
        .o_found     (found),
        .o_index     (found_index)
);

// Line and tag stay put while the clean index is held
wb_burst_writer #(.CACHE_LINE(CACHE_LINE)) u_wb_writer (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_start  (wb_start),
        .i_line   (o_line),
        .i_tag    (o_tag),
        .i_wb_ack (i_wb_ack),
        .o_done   (wb_done),
        .o_wb_cyc (o_wb_cyc),
        .o_wb_stb (o_wb_stb),
        .o_wb_we  (o_wb_we),
        .o_wb_adr (o_wb_adr),
        .o_wb_dat (o_wb_dat),
        .o_wb_sel (o_wb_sel),
        .o_wb_cti (o_wb_cti)
);

endmodule

// File: hdl/clean_ctrl.sv
/*
 * Cache array controller
 * Handles normal access, the clean walk over dirty lines and invalidation
 */
module clean_ctrl
        import cache_pkg::*;
#(
        parameter int CACHE_SIZE = 512,
        parameter int CACHE_LINE = 16,
        parameter int GRP_W      = 1
) (
        input  logic                                      i_clk,
        input  logic                                      i_reset,
        input  logic [31:0]                               i_address_nxt,
        input  logic [31:0]                               i_address,
        input  logic                                      i_tag_wr_en,
        input  logic                                      i_clean_req,
        input  logic                                      i_inv_req,
        input  logic                                      i_found,
        input  logic [$clog2(CACHE_SIZE/CACHE_LINE)-1:0]  i_index,
        input  logic                                      i_wb_done,
        array_access_if.ctrl                              acc,
        output logic [GRP_W-1:0]                          o_group,
        output logic                                      o_wb_start,
        output logic                                      o_clean_done,
        output logic                                      o_inv_done
);

localparam int LINES  = CACHE_SIZE / CACHE_LINE;
localparam int IDX_W  = $clog2(LINES);
localparam int OFF_W  = $clog2(CACHE_LINE);
localparam int GROUPS = LINES / GROUP_LINES;

ctrl_state_t      state;
logic [IDX_W-1:0] clean_idx;
logic             req_ok;

// A done pulse still high means the requester has not yet dropped
assign req_ok = !o_clean_done && !o_inv_done;

// ------------------------------
// Array controls
// ------------------------------
always_comb
begin
        acc.rd_index = (state == IDLE) ? i_address_nxt[OFF_W +: IDX_W] : clean_idx;
        acc.wr_index = i_address[OFF_W +: IDX_W];
        acc.wr_en    = (state == IDLE) && i_tag_wr_en;
        acc.clean_en = (state == WRITE_BACK) && i_wb_done;
        acc.clear_en = (state == INVALIDATE);
end

// ------------------------------
// State machine
// ------------------------------
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state        <= IDLE;
                o_group      <= '0;
                clean_idx    <= '0;
                o_wb_start   <= 1'b0;
                o_clean_done <= 1'b0;
                o_inv_done   <= 1'b0;
        end
        else
        begin
                o_wb_start   <= 1'b0;
                o_clean_done <= 1'b0;
                o_inv_done   <= 1'b0;

                case (state)
                IDLE:
                begin
                        // Clean wins over invalidate
                        if (i_clean_req && req_ok)
                        begin
                                o_group <= '0;
                                state   <= SCAN;
                        end
                        else if (i_inv_req && req_ok)
                        begin
                                state <= INVALIDATE;
                        end
                end
                SCAN:
                begin
                        if (i_found)
                        begin
                                clean_idx <= i_index;
                                state     <= READ_WAIT;
                        end
                        else if (o_group == GRP_W'(GROUPS - 1))
                        begin
                                o_group      <= '0;
                                o_clean_done <= 1'b1;
                                state        <= IDLE;
                        end
                        else
                        begin
                                o_group <= o_group + 1'b1;
                        end
                end
                READ_WAIT:
                begin
                        // RAM output is valid on the next cycle
                        o_wb_start <= 1'b1;
                        state      <= WRITE_BACK;
                end
                WRITE_BACK:
                begin
                        if (i_wb_done)
                        begin
                                state <= SCAN;
                        end
                end
                INVALIDATE:
                begin
                        o_inv_done <= 1'b1;
                        state      <= IDLE;
                end
                default:
                begin
                        state <= IDLE;
                end
                endcase
        end
end

endmodule

// File: hdl/wb_burst_writer.sv
/*
 * Wishbone burst writer
 * Writes one cache line word by word to its physical address,
 * low word first, with an incrementing burst ending on EOB
 */
module wb_burst_writer
        import cache_pkg::*;
#(
        parameter int CACHE_LINE = 16
) (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_start,
        input  logic [CACHE_LINE*8-1:0] i_line,
        input  tag_t                  i_tag,
        input  logic                  i_wb_ack,
        output logic                  o_done,
        output logic                  o_wb_cyc,
        output logic                  o_wb_stb,
        output logic                  o_wb_we,
        output logic [WB_AW-1:0]      o_wb_adr,
        output logic [WB_DW-1:0]      o_wb_dat,
        output logic [WB_SEL_W-1:0]   o_wb_sel,
        output logic [2:0]            o_wb_cti
);

localparam int WORDS = CACHE_LINE / 4;
localparam int CNT_W = (WORDS > 1) ? $clog2(WORDS) : 1;

logic [CNT_W-1:0] cnt;
logic [CNT_W-1:0] nxt;
logic             last;
logic             acked;
logic             at_end;
logic             load;

// Word to present next, either the first or the one after an ack
always_comb
begin
        nxt    = i_start ? '0 : cnt + 1'b1;
        last   = (nxt == CNT_W'(WORDS - 1));
        acked  = o_wb_stb && i_wb_ack;
        at_end = (cnt == CNT_W'(WORDS - 1));
        load   = i_start || (acked && !at_end);
end

// ------------------------------
// Bus control
// ------------------------------
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_wb_cyc <= 1'b0;
                o_wb_stb <= 1'b0;
                o_wb_we  <= 1'b0;
                o_wb_cti <= CTI_CLASSIC;
                o_done   <= 1'b0;
                cnt      <= '0;
        end
        else
        begin
                o_done <= 1'b0;
                if (load)
                begin
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                        o_wb_we  <= 1'b1;
                        o_wb_cti <= last ? CTI_EOB : CTI_BURST;
                        cnt      <= nxt;
                end
                else if (acked)
                begin
                        // Last word taken, release the bus
                        o_wb_cyc <= 1'b0;
                        o_wb_stb <= 1'b0;
                        o_wb_we  <= 1'b0;
                        o_wb_cti <= CTI_CLASSIC;
                        o_done   <= 1'b1;
                end
        end
end

// Address and data hold until the slave acks
always_ff @(posedge i_clk)
begin
        if (load)
        begin
                o_wb_adr <= i_tag.pa_base + {nxt, 2'b00};
                o_wb_dat <= i_line[nxt * WB_DW +: WB_DW];
                o_wb_sel <= '1;
        end
end

endmodule

// File: hdl/dirty_scan.sv
/*
 * Dirty line scan
 * Finds the lowest dirty line inside one 16-line group
 */
module dirty_scan
        import cache_pkg::*;
#(
        parameter int LINES = 32,
        parameter int GRP_W = 1
) (
        input  logic [LINES-1:0]         i_dirty_vec,
        input  logic [GRP_W-1:0]         i_group,
        output logic                     o_found,
        output logic [$clog2(LINES)-1:0] o_index
);

localparam int IDX_W = $clog2(LINES);
localparam int POS_W = $clog2(GROUP_LINES);

logic [GROUP_LINES-1:0] bits;
logic [POS_W-1:0]       pos;

always_comb
begin
        bits = i_dirty_vec[i_group * GROUP_LINES +: GROUP_LINES];
        pos  = '0;

        // Walk downward so the lowest set bit is kept
        for (int j = GROUP_LINES - 1; j >= 0; j--)
        begin
                if (bits[j])
                begin
                        pos = POS_W'(j);
                end
        end

        o_found = |bits;
        o_index = IDX_W'(i_group * GROUP_LINES + pos);
end

endmodule

// File: hdl/line_state.sv
/*
 * Line state bits
 * Valid and dirty flag per line, read out in step with the RAMs
 */
module line_state #(
        parameter int LINES = 32
) (
        input  logic             i_clk,
        input  logic             i_reset,
        input  logic             i_tag_dirty,
        array_access_if.array    acc,
        output logic             o_valid,
        output logic             o_dirty,
        output logic [LINES-1:0] o_dirty_vec
);

logic [LINES-1:0] valid;
logic [LINES-1:0] dirty;

assign o_dirty_vec = dirty;

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                valid   <= '0;
                dirty   <= '0;
                o_valid <= 1'b0;
                o_dirty <= 1'b0;
        end
        else
        begin
                // Registered read, one cycle like the RAMs
                o_valid <= valid[acc.rd_index];
                o_dirty <= dirty[acc.rd_index];

                if (acc.clear_en)
                begin
                        valid <= '0;
                end
                else if (acc.wr_en)
                begin
                        valid[acc.wr_index] <= 1'b1;
                end

                // A fresh write wins over a write-back clean
                if (acc.wr_en)
                begin
                        dirty[acc.wr_index] <= i_tag_dirty;
                end
                else if (acc.clean_en)
                begin
                        dirty[acc.rd_index] <= 1'b0;
                end
        end
end

endmodule

// File: hdl/line_ram.sv
/*
 * Line RAM
 * One write port and one registered read port, payload set by type
 */
module line_ram #(
        parameter type payload_t = logic [31:0],
        parameter int  DEPTH     = 32
) (
        input  logic                     i_clk,
        input  logic                     i_wr_en,
        input  logic [$clog2(DEPTH)-1:0] i_wr_index,
        input  payload_t                 i_wr_data,
        input  logic [$clog2(DEPTH)-1:0] i_rd_index,
        output payload_t                 o_rd_data
);

payload_t mem [DEPTH];

// Same-index read during a write returns the old entry
always_ff @(posedge i_clk)
begin
        if (i_wr_en)
        begin
                mem[i_wr_index] <= i_wr_data;
        end
        o_rd_data <= mem[i_rd_index];
end

endmodule

// File: hdl/array_access_if.sv
/*
 * Array access interface
 * Index and write controls from the cache controller to the storage arrays
 */
interface array_access_if #(
        parameter int IDX_W = 5
);

logic [IDX_W-1:0] rd_index;
logic [IDX_W-1:0] wr_index;
logic             wr_en;
// Drop the dirty bit of the line at rd_index
logic             clean_en;
// Drop every valid bit
logic             clear_en;

modport ctrl (
        output rd_index, wr_index, wr_en, clean_en, clear_en
);

modport array (
        input  rd_index, wr_index, wr_en, clean_en, clear_en
);

endinterface

// File: hdl/cache_pkg.sv
/*
 * Cache tag RAM shared definitions
 * Tag format, Wishbone widths and cycle types, and controller states
 */
package cache_pkg;

// Wishbone bus widths
localparam int WB_AW    = 32;
localparam int WB_DW    = 32;
localparam int WB_SEL_W = 4;

// Dirty bits examined per scan step
localparam int GROUP_LINES = 16;

// Cycle type indicator codes
localparam logic [2:0] CTI_CLASSIC = 3'b000;
localparam logic [2:0] CTI_BURST   = 3'b010;
localparam logic [2:0] CTI_EOB     = 3'b111;

localparam int VA_TAG_W = 16;

// Virtual tag plus physical byte address of the line
typedef struct packed {
        logic [VA_TAG_W-1:0] va_tag;
        logic [WB_AW-1:0]    pa_base;
} tag_t;

typedef enum logic [2:0] {
        IDLE,
        SCAN,
        READ_WAIT,
        WRITE_BACK,
        INVALIDATE
} ctrl_state_t;

endpackage
